//--- two_way_cache_params.svh
`ifndef TWO_WAY_CACHE_PARAMS_SVH
`define TWO_WAY_CACHE_PARAMS_SVH

// Processor word and byte address widths
`define ADDR_W 16
`define DATA_W 16

// Address split: tag 15:10, set 9:4, word 3:1
`define TAG_W 6
`define SET_W 6
`define WORD_W 3
`define TAG_LSB 10
`define SET_LSB 4
`define WORD_LSB 1

`define SETS 64
`define WORDS 8
`define META_W 8

// Backing memory
`define MEM_WORDS 32768
`define MEM_LATENCY 4
`define MEM_INIT_KEY 16'hA5C3

`endif

//--- two_way_cache_pkg.sv
`include "two_way_cache_params.svh"

package two_way_cache_pkg;

    // Refill controller states
    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_drain,
        st_tag
    } refill_state_t;

    // One metadata word per set and way, LRU only meaningful in way 0
    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic              valid;
        logic              lru;   // 1 means way 0 was used last
    } meta_t;

endpackage

//--- refill_if.sv
`timescale 1ns/1ps
`include "two_way_cache_params.svh"

interface refill_if (
    input logic clk
);

    logic                  miss;
    logic                  fill_we;     // One strobe per returned word
    logic [`WORD_W-1:0]    fill_index;
    logic [`DATA_W-1:0]    fill_data;
    logic                  tag_we;      // Writes the victim's tag and valid bit

    modport cache_port (
        input  clk,
        output miss,
        input  fill_we, fill_index, fill_data, tag_we
    );

    modport ctrl_port (
        input  clk,
        input  miss,
        output fill_we, fill_index, tag_we
    );

    modport mem_port (input clk, output fill_data);

endinterface

//--- sram_array.sv
`timescale 1ns/1ps

module sram_array #(
    parameter int WIDTH      = 16,
    parameter int DEPTH_BITS = 9
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [DEPTH_BITS-1:0] waddr,
    input  logic [WIDTH-1:0]      wdata,
    input  logic [DEPTH_BITS-1:0] raddr,
    output logic [WIDTH-1:0]      rdata
);

    localparam int DEPTH = 1 << DEPTH_BITS;

    logic [WIDTH-1:0] mem [DEPTH];

    // The metadata ways rely on this clear to drop every valid bit
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];   // Hits resolve in the same cycle

endmodule

//--- word_counter.sv
`timescale 1ns/1ps
`include "two_way_cache_params.svh"

module word_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               clear,
    input  logic               step,
    output logic [`WORD_W-1:0] count,
    output logic               last
);

    localparam logic [`WORD_W-1:0] LAST_WORD = `WORD_W'(`WORDS - 1);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;   // Wraps back to word 0 after the block
        end
    end

    // High in the cycle the final word of the block is counted
    assign last = step && (count == LAST_WORD);

endmodule

//--- main_memory.sv
`timescale 1ns/1ps
`include "two_way_cache_params.svh"

module main_memory (
    input  logic               clk,
    input  logic               reset,
    input  logic               rd_req,
    input  logic [`ADDR_W-2:0] rd_addr,
    output logic               rdata_valid,
    output logic [`DATA_W-1:0] rdata,
    input  logic               wr_en,
    input  logic [`ADDR_W-2:0] wr_addr,
    input  logic [`DATA_W-1:0] wr_data,
    refill_if.mem_port         rif
);

    localparam int L = `MEM_LATENCY;

    logic [`DATA_W-1:0] mem [`MEM_WORDS];
    logic [L-1:0]       valid_pipe;
    logic [`DATA_W-1:0] data_pipe [L];

    // Word w starts out as w XOR the key
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = `DATA_W'(i) ^ `MEM_INIT_KEY;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ------------------------------------------------------------
    // Read latency pipeline
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[L-2:0], rd_req};
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[rd_addr];
        for (int i = 1; i < L; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rdata_valid   = valid_pipe[L-1];
    assign rdata         = data_pipe[L-1];
    assign rif.fill_data = rdata;   // Refill words go straight into the cache

endmodule

//--- cache.sv
`timescale 1ns/1ps
`include "two_way_cache_params.svh"

module cache import two_way_cache_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`DATA_W-1:0] data_in,
    input  logic               en,
    input  logic               wen,
    output logic [`DATA_W-1:0] data_out,
    refill_if.cache_port       rif
);

    localparam int DATA_AW = $clog2(`SETS * `WORDS);
    localparam int META_AW = $clog2(`SETS);

    logic [`TAG_W-1:0]  tag_field;
    logic [`SET_W-1:0]  set_field;
    logic [`WORD_W-1:0] word_field;
    logic [`WORD_W-1:0] data_word;
    logic [`DATA_W-1:0] data_wdata;
    logic [`DATA_W-1:0] data0_q;
    logic [`DATA_W-1:0] data1_q;
    logic               data0_we;
    logic               data1_we;
    meta_t              meta0_q;
    meta_t              meta1_q;
    meta_t              meta0_d;
    meta_t              meta1_d;
    logic               meta0_we;
    logic               meta1_we;
    logic               access;
    logic               hit0;
    logic               hit1;
    logic               hit;
    logic               victim;

    assign tag_field  = addr[`TAG_LSB +: `TAG_W];
    assign set_field  = addr[`SET_LSB +: `SET_W];
    assign word_field = addr[`WORD_LSB +: `WORD_W];

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    sram_array #(.WIDTH(`DATA_W), .DEPTH_BITS(DATA_AW)) data_way0 (
        .clk(clk), .reset(reset), .we(data0_we),
        .waddr({set_field, data_word}), .wdata(data_wdata),
        .raddr({set_field, data_word}), .rdata(data0_q)
    );

    sram_array #(.WIDTH(`DATA_W), .DEPTH_BITS(DATA_AW)) data_way1 (
        .clk(clk), .reset(reset), .we(data1_we),
        .waddr({set_field, data_word}), .wdata(data_wdata),
        .raddr({set_field, data_word}), .rdata(data1_q)
    );

    sram_array #(.WIDTH(`META_W), .DEPTH_BITS(META_AW)) meta_way0 (
        .clk(clk), .reset(reset), .we(meta0_we),
        .waddr(set_field), .wdata(meta0_d),
        .raddr(set_field), .rdata(meta0_q)
    );

    sram_array #(.WIDTH(`META_W), .DEPTH_BITS(META_AW)) meta_way1 (
        .clk(clk), .reset(reset), .we(meta1_we),
        .waddr(set_field), .wdata(meta1_d),
        .raddr(set_field), .rdata(meta1_q)
    );

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------
    assign access   = en | wen;
    assign hit0     = meta0_q.valid && (meta0_q.tag == tag_field);
    assign hit1     = meta1_q.valid && (meta1_q.tag == tag_field);
    assign hit      = access & (hit0 | hit1);
    assign rif.miss = access & ~hit0 & ~hit1;
    assign victim   = meta0_q.lru;   // Way 1 goes out when way 0 was used last

    assign data_out = hit0 ? data0_q : data1_q;

    // Refill words land in the victim way, otherwise a write hit updates its way
    assign data_word  = rif.fill_we ? rif.fill_index : word_field;
    assign data_wdata = rif.fill_we ? rif.fill_data : data_in;
    assign data0_we   = (rif.fill_we & ~victim) | (hit & hit0 & wen);
    assign data1_we   = (rif.fill_we & victim) | (hit & hit1 & wen);

    always_comb begin
        meta0_d  = meta0_q;
        meta1_d  = meta1_q;
        meta0_we = 1'b0;
        meta1_we = 1'b0;
        if (rif.tag_we) begin
            if (victim) begin
                meta1_d     = '{tag: tag_field, valid: 1'b1, lru: 1'b0};
                meta1_we    = 1'b1;
                meta0_d.lru = 1'b0;   // Way 1 is now the newest
                meta0_we    = 1'b1;
            end else begin
                meta0_d  = '{tag: tag_field, valid: 1'b1, lru: 1'b1};
                meta0_we = 1'b1;
            end
        end else if (hit) begin
            meta0_d.lru = hit0;
            meta0_we    = 1'b1;
        end
    end

endmodule

//--- miss_fsm.sv
`timescale 1ns/1ps
`include "two_way_cache_params.svh"

module miss_fsm import two_way_cache_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [`ADDR_W-1:0] addr,
    refill_if.ctrl_port        rif,
    output logic               rd_req,
    output logic [`ADDR_W-2:0] rd_addr,
    output logic               issue_clear,
    output logic               issue_step,
    input  logic [`WORD_W-1:0] issue_count,
    input  logic               issue_last,
    output logic               fill_step,
    output logic               fill_clear,
    input  logic [`WORD_W-1:0] fill_count,
    input  logic               fill_last,
    input  logic               rdata_valid,
    output logic               stall
);

    refill_state_t state;
    refill_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle:  if (rif.miss) state_next = st_fetch;
            st_fetch: if (issue_last) state_next = st_drain;   // Eighth read goes out
            st_drain: if (fill_last) state_next = st_tag;
            st_tag:   state_next = st_idle;
            default:  state_next = st_idle;
        endcase
    end

    // ------------------------------------------------------------
    // Block read issue
    // ------------------------------------------------------------
    assign rd_req      = (state == st_fetch);
    assign rd_addr     = {addr[`TAG_LSB +: `TAG_W], addr[`SET_LSB +: `SET_W], issue_count};
    assign issue_step  = (state == st_fetch);
    assign issue_clear = (state == st_idle);

    // Returned words are written as they arrive, in issue order
    assign fill_step      = rdata_valid;
    assign fill_clear     = (state == st_idle);
    assign rif.fill_we    = rdata_valid;
    assign rif.fill_index = fill_count;
    assign rif.tag_we     = (state == st_tag);

    assign stall = rif.miss | (state != st_idle);

endmodule

//--- cache_system.sv
`timescale 1ns/1ps
`include "two_way_cache_params.svh"

module cache_system (
    input  logic               clk,
    input  logic               reset,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`DATA_W-1:0] data_in,
    input  logic               en,
    input  logic               wen,
    output logic [`DATA_W-1:0] data_out,
    output logic               stall
);

    logic               rd_req;
    logic [`ADDR_W-2:0] rd_addr;
    logic               rdata_valid;
    logic               issue_clear;
    logic               issue_step;
    logic [`WORD_W-1:0] issue_count;
    logic               issue_last;
    logic               fill_clear;
    logic               fill_step;
    logic [`WORD_W-1:0] fill_count;
    logic               fill_last;
    logic               wr_en;

    refill_if rif (.clk(clk));

    cache cache_inst (.clk, .reset, .addr, .data_in, .en, .wen, .data_out, .rif(rif.cache_port));

    miss_fsm miss_fsm_inst (
        .clk, .reset, .addr, .rif(rif.ctrl_port), .rd_req, .rd_addr,
        .issue_clear, .issue_step, .issue_count, .issue_last,
        .fill_step, .fill_clear, .fill_count, .fill_last, .rdata_valid, .stall
    );

    word_counter issue_counter (.clk, .reset, .clear(issue_clear), .step(issue_step),
                                .count(issue_count), .last(issue_last));
    word_counter fill_counter (.clk, .reset, .clear(fill_clear), .step(fill_step),
                               .count(fill_count), .last(fill_last));

    // Write-through happens on the edge that completes a write hit
    assign wr_en = wen & ~stall;

    main_memory memory_inst (
        .clk, .reset, .rd_req, .rd_addr, .rdata_valid, .rdata(), .wr_en,
        .wr_addr(addr[`ADDR_W-1:1]), .wr_data(data_in), .rif(rif.mem_port)
    );

endmodule

//--- cache_sva.sv
`timescale 1ns/1ps
`include "two_way_cache_params.svh"

module cache_sva import two_way_cache_pkg::*; (
    input logic          clk,
    input logic          reset,
    input logic          stall,
    input logic          rd_req,
    input logic          tag_we,
    input logic          fill_last,
    input refill_state_t state
);

    int failures = 0;   // Number of failed assertions

    // All valid bits are gone, so an idle port cannot stall
    stall_after_reset: assert property (@(posedge clk) $fell(reset) |-> !stall)
        else begin
            $error("stall is high in the first cycle after reset");
            failures++;
        end

    // ------------------------------------------------------------
    // Refill protocol
    // ------------------------------------------------------------
    // The last word returns one memory latency after the last read, then the tag is written
    tag_after_fill: assert property (@(posedge clk) disable iff (reset)
        tag_we |-> $past(fill_last) && $past(rd_req, `MEM_LATENCY + 1)
                   && !$past(rd_req, `MEM_LATENCY))
        else begin
            $error("tag_we is not a single strobe right after the last fill");
            failures++;
        end

    // A block is fetched with back-to-back reads, one per word, before the FSM drains
    block_read_burst: assert property (@(posedge clk) disable iff (reset)
        $fell(rd_req) |-> state == st_drain && $past(rd_req, `WORDS)
                          && !$past(rd_req, `WORDS + 1))
        else begin
            $error("rd_req burst does not cover exactly one block");
            failures++;
        end

endmodule

//--- cache_checker.sv
`timescale 1ns/1ps
`include "two_way_cache_params.svh"

module cache_checker import two_way_cache_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`DATA_W-1:0] data_in,
    input  logic               en,
    input  logic               wen,
    input  logic [`DATA_W-1:0] data_out,
    input  logic               stall,
    input  logic               exp_valid,
    input  logic               exp_hit,
    output int                 data_errors,
    output int                 hit_errors,
    output int                 stall_errors,
    output int                 completed
);

    localparam int MISS_CYCLES = 10 + `MEM_LATENCY;

    logic [`DATA_W-1:0] shadow [`MEM_WORDS];   // Memory contents after write-through
    meta_t              dir0 [`SETS];
    meta_t              dir1 [`SETS];
    logic               busy;
    logic               was_miss;
    int                 stall_cycles;

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            shadow[i] = `DATA_W'(i) ^ `MEM_INIT_KEY;
        end
    end

    always @(posedge clk) begin
        logic [`TAG_W-1:0]  req_tag;
        logic [`SET_W-1:0]  set_idx;
        logic [`ADDR_W-2:0] waddr;
        logic               hit0;
        logic               hit1;
        logic               way;
        req_tag = addr[`TAG_LSB +: `TAG_W];
        set_idx = addr[`SET_LSB +: `SET_W];
        waddr   = addr[`ADDR_W-1:1];
        hit0    = dir0[set_idx].valid && (dir0[set_idx].tag == req_tag);
        hit1    = dir1[set_idx].valid && (dir1[set_idx].tag == req_tag);
        if (reset) begin
            for (int s = 0; s < `SETS; s++) begin
                dir0[s] = '0;
                dir1[s] = '0;
            end
            busy         = 1'b0;
            was_miss     = 1'b0;
            stall_cycles = 0;
            data_errors  = 0;
            hit_errors   = 0;
            stall_errors = 0;
            completed    = 0;
        end else if (en || wen) begin
            // First cycle of a request decides hit or miss
            if (!busy) begin
                was_miss     = !(hit0 || hit1);
                stall_cycles = 0;
                if (stall != was_miss) begin
                    hit_errors++;
                    $display("ERR %0t: addr 0x%h model predicts miss=%b, stall=%b",
                             $time, addr, was_miss, stall);
                end
                if (exp_valid && (exp_hit == stall)) begin
                    hit_errors++;
                    $display("ERR %0t: addr 0x%h table expects hit=%b, stall=%b",
                             $time, addr, exp_hit, stall);
                end
            end
            if (stall) begin
                busy = 1'b1;
                stall_cycles++;
            end else begin
                if (was_miss && stall_cycles != MISS_CYCLES) begin
                    stall_errors++;
                    $display("ERR %0t: addr 0x%h stalled %0d cycles, expected %0d",
                             $time, addr, stall_cycles, MISS_CYCLES);
                end
                // A miss fills the LRU victim, way 1 when way 0 was used last
                way = was_miss ? dir0[set_idx].lru : hit1;
                if (was_miss && way) begin
                    dir1[set_idx] = '{tag: req_tag, valid: 1'b1, lru: 1'b0};
                end else if (was_miss) begin
                    dir0[set_idx].tag   = req_tag;
                    dir0[set_idx].valid = 1'b1;
                end
                dir0[set_idx].lru = ~way;
                if (en && (data_out !== shadow[waddr])) begin
                    data_errors++;
                    $display("ERR %0t: read 0x%h returned 0x%h, expected 0x%h",
                             $time, addr, data_out, shadow[waddr]);
                end
                if (wen) begin
                    shadow[waddr] = data_in;
                end
                completed++;
                busy = 1'b0;
            end
        end
    end

endmodule

//--- cache_tb.sv
`timescale 1ns/1ps
`include "two_way_cache_params.svh"

module cache_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int N_TABLE      = 16;
    localparam int N_RANDOM     = 120;
    localparam int MISS_CYCLES  = 10 + `MEM_LATENCY;
    localparam int WATCHDOG_NS  = (N_TABLE + N_RANDOM) * (MISS_CYCLES + 2) * CLK_PERIOD * 2;

    typedef struct packed {
        logic               write;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
        logic               hit;
    } entry_t;

    logic               clk;
    logic               reset;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data_in;
    logic               en;
    logic               wen;
    logic [`DATA_W-1:0] data_out;
    logic               stall;
    logic               exp_valid;
    logic               exp_hit;
    int                 data_errors;
    int                 hit_errors;
    int                 stall_errors;
    int                 completed;
    entry_t             stim [N_TABLE];

    cache_system UUT (.clk, .reset, .addr, .data_in, .en, .wen, .data_out, .stall);

    cache_checker checker_inst (
        .clk, .reset, .addr, .data_in, .en, .wen, .data_out, .stall,
        .exp_valid, .exp_hit, .data_errors, .hit_errors, .stall_errors, .completed
    );

    bind cache_system cache_sva sva_inst (
        .clk(clk), .reset(reset), .stall(stall), .rd_req(rd_req),
        .tag_we(rif.tag_we), .fill_last(fill_last), .state(miss_fsm_inst.state)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [`ADDR_W-1:0] block_addr(input int tag, input int set_idx,
                                                      input int word);
        return {tag[`TAG_W-1:0], set_idx[`SET_W-1:0], word[`WORD_W-1:0], 1'b0};
    endfunction

    // Presents one request and returns on the edge that completes it
    task automatic run_request(input logic write, input logic [`ADDR_W-1:0] a,
                               input logic [`DATA_W-1:0] d, input logic check, input logic hit);
        addr      <= a;
        data_in   <= d;
        en        <= ~write;
        wen       <= write;
        exp_valid <= check;
        exp_hit   <= hit;
        do begin
            @(posedge clk);
        end while (stall);
    endtask

    initial begin
        logic               r_write;
        logic [`ADDR_W-1:0] r_addr;
        int                 total;
        clk       = 1'b0;
        reset     = 1'b1;
        addr      = '0;
        data_in   = '0;
        en        = 1'b0;
        wen       = 1'b0;
        exp_valid = 1'b0;
        exp_hit   = 1'b0;
        void'($urandom(69839));

        // Cold miss, hits in the block, write hit and readback
        stim[0]  = '{1'b0, block_addr(1, 5, 0), 16'h0000, 1'b0};
        stim[1]  = '{1'b0, block_addr(1, 5, 3), 16'h0000, 1'b1};
        stim[2]  = '{1'b0, block_addr(1, 5, 7), 16'h0000, 1'b1};
        stim[3]  = '{1'b1, block_addr(1, 5, 2), 16'h1234, 1'b1};
        stim[4]  = '{1'b0, block_addr(1, 5, 2), 16'h0000, 1'b1};
        stim[5]  = '{1'b0, block_addr(2, 5, 0), 16'h0000, 1'b0};
        stim[6]  = '{1'b0, block_addr(1, 5, 1), 16'h0000, 1'b1};
        stim[7]  = '{1'b0, block_addr(3, 5, 0), 16'h0000, 1'b0};   // Evicts tag 2, not tag 1
        stim[8]  = '{1'b0, block_addr(1, 5, 4), 16'h0000, 1'b1};
        stim[9]  = '{1'b0, block_addr(2, 5, 0), 16'h0000, 1'b0};
        // Push tag 1 out and bring the written word back from memory
        stim[10] = '{1'b0, block_addr(3, 5, 0), 16'h0000, 1'b0};
        stim[11] = '{1'b0, block_addr(1, 5, 2), 16'h0000, 1'b0};
        stim[12] = '{1'b1, block_addr(4, 9, 5), 16'hBEEF, 1'b0};   // Write miss
        stim[13] = '{1'b0, block_addr(4, 9, 5), 16'h0000, 1'b1};
        stim[14] = '{1'b0, block_addr(4, 9, 4), 16'h0000, 1'b1};
        stim[15] = '{1'b0, block_addr(4, 9, 7), 16'h0000, 1'b1};

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        for (int i = 0; i < N_TABLE; i++) begin
            run_request(stim[i].write, stim[i].addr, stim[i].data, 1'b1, stim[i].hit);
        end

        // Four sets and five tags keep the two ways under pressure
        for (int i = 0; i < N_RANDOM; i++) begin
            r_write = ($urandom % 3) == 0;
            r_addr  = block_addr(int'($urandom % 5), 32 + int'($urandom % 4),
                                 int'($urandom % 8));
            run_request(r_write, r_addr, 16'($urandom), 1'b0, 1'b0);
        end

        en        <= 1'b0;
        wen       <= 1'b0;
        exp_valid <= 1'b0;
        repeat (4) @(posedge clk);

        total = data_errors + hit_errors + stall_errors + UUT.sva_inst.failures;
        if (completed != N_TABLE + N_RANDOM) begin
            $display("Only %0d of %0d requests completed", completed, N_TABLE + N_RANDOM);
            total++;
        end
        $display("Errors: data %0d, hit/miss %0d, stall %0d, assertions %0d",
                 data_errors, hit_errors, stall_errors, UUT.sva_inst.failures);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with requests still pending", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- two_way_cache.f
+incdir+.
two_way_cache_pkg.sv
refill_if.sv
sram_array.sv
word_counter.sv
main_memory.sv
cache.sv
miss_fsm.sv
cache_system.sv
cache_sva.sv
cache_checker.sv
cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module cache_tb -f two_way_cache.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Raise the error limit so failed assertions do not end the run early
./obj_dir/Vcache_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0
